//--- filelist.f
+incdir+hw
hw/dual_issue_pkg.sv
hw/issue_buffer.sv
hw/execute_pair.sv
hw/stage_regs.sv
hw/mem_stage.sv
hw/retire_port.sv
hw/dual_issue_top.sv
sim/tb_checker.sv
sim/tb_dual_issue.sv

//--- hw/dual_issue_params.svh
`ifndef DUAL_ISSUE_PARAMS_SVH
`define DUAL_ISSUE_PARAMS_SVH

// Width of data, PCs and results
`define DI_XLEN 32

// Pair slots in the issue buffer, equal to the upstream's starting credits
`define DI_ISSUE_DEPTH 4

// Starting credits of the retire consumer
`define DI_RETIRE_CREDITS 2

`endif

//--- hw/dual_issue_pkg.sv
package dual_issue_pkg;

    // Opcode of one slot, also its writeback select in MEM
    typedef enum logic [3:0] {
        OP_NOP     = 4'h0,
        OP_ADD     = 4'h1,
        OP_SUB     = 4'h2,
        OP_AND     = 4'h3,
        OP_OR      = 4'h4,
        OP_XOR     = 4'h5,
        OP_SLT     = 4'h6,  // Signed compare
        OP_MUL     = 4'h7,  // Slot B only
        OP_BEQ     = 4'h8,  // Slot A only
        OP_SYSCALL = 4'h9
    } alu_op_e;

    // Exception code raised in MEM, zero means none
    typedef enum logic [6:0] {
        ECODE_NONE    = 7'h00,
        ECODE_SYS     = 7'h0b,
        ECODE_ILLEGAL = 7'h0d   // Opcode in the wrong slot
    } ecode_e;

endpackage

//--- hw/dual_issue_top.sv
`timescale 1ns/1ps
`include "dual_issue_params.svh"

module dual_issue_top import dual_issue_pkg::*; (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                in_valid,
    input  logic [`DI_XLEN-1:0] in_pc_a,
    input  alu_op_e             in_op_a,
    input  logic [`DI_XLEN-1:0] in_src1_a,
    input  logic [`DI_XLEN-1:0] in_src2_a,
    input  logic [4:0]          in_rd_a,
    input  logic                in_we_a,
    input  logic [`DI_XLEN-1:0] in_pc_b,
    input  alu_op_e             in_op_b,
    input  logic [`DI_XLEN-1:0] in_src1_b,
    input  logic [`DI_XLEN-1:0] in_src2_b,
    input  logic [4:0]          in_rd_b,
    input  logic                in_we_b,
    output logic                in_credit,
    input  logic                flush,
    input  logic                retire_credit,
    output logic                retire_valid,
    output logic [`DI_XLEN-1:0] retire_pc_a,
    output logic [`DI_XLEN-1:0] retire_pc_b,
    output logic                retire_we_a,
    output logic                retire_we_b,
    output logic [4:0]          retire_rd_a,
    output logic [4:0]          retire_rd_b,
    output logic [`DI_XLEN-1:0] retire_wdata_a,
    output logic [`DI_XLEN-1:0] retire_wdata_b
);

    // Buffer head
    logic                head_valid, head_we_a, head_we_b;
    logic [`DI_XLEN-1:0] head_pc_a, head_pc_b;
    logic [`DI_XLEN-1:0] head_src1_a, head_src2_a, head_src1_b, head_src2_b;
    alu_op_e             head_op_a, head_op_b;
    logic [4:0]          head_rd_a, head_rd_b;

    // EX outputs
    logic                ex_valid, ex_we_a, ex_we_b, br_a;
    logic [`DI_XLEN-1:0] ex_pc_a, ex_pc_b, ex_result_a, ex_result_b;
    alu_op_e             ex_op_a, ex_op_b;
    logic [4:0]          ex_rd_a, ex_rd_b;
    logic [63:0]         mul_lo_part, mul_hi_part;

    // MEM stage
    alu_op_e             mem_op_a, mem_op_b;
    logic [`DI_XLEN-1:0] mem_result_a, mem_result_b, mem_wdata_a, mem_wdata_b;
    logic [63:0]         mem_mul_lo, mem_mul_hi;
    ecode_e              mem_ecode_a, mem_ecode_b;

    // WB record
    logic                wb_valid, wb_we_a, wb_we_b;
    logic [`DI_XLEN-1:0] wb_pc_a, wb_pc_b, wb_wdata_a, wb_wdata_b;
    logic [4:0]          wb_rd_a, wb_rd_b;

    logic                stall;

    issue_buffer i_issue_buffer (.advance(!stall), .*);

    execute_pair i_execute_pair (.*);

    // MEM valid and PCs only travel on to WB
    stage_regs i_stage_regs (.mem_valid(), .mem_pc_a(), .mem_pc_b(), .*);

    mem_stage i_mem_stage (.*);

    retire_port i_retire_port (.*);

endmodule

//--- hw/execute_pair.sv
`timescale 1ns/1ps
`include "dual_issue_params.svh"

module execute_pair import dual_issue_pkg::*; (
    input  logic                head_valid,
    input  logic [`DI_XLEN-1:0] head_pc_a,
    input  alu_op_e             head_op_a,
    input  logic [`DI_XLEN-1:0] head_src1_a,
    input  logic [`DI_XLEN-1:0] head_src2_a,
    input  logic [4:0]          head_rd_a,
    input  logic                head_we_a,
    input  logic [`DI_XLEN-1:0] head_pc_b,
    input  alu_op_e             head_op_b,
    input  logic [`DI_XLEN-1:0] head_src1_b,
    input  logic [`DI_XLEN-1:0] head_src2_b,
    input  logic [4:0]          head_rd_b,
    input  logic                head_we_b,
    output logic                ex_valid,
    output logic [`DI_XLEN-1:0] ex_pc_a,
    output logic [`DI_XLEN-1:0] ex_pc_b,
    output alu_op_e             ex_op_a,
    output alu_op_e             ex_op_b,
    output logic [4:0]          ex_rd_a,
    output logic [4:0]          ex_rd_b,
    output logic                ex_we_a,
    output logic                ex_we_b,
    output logic [`DI_XLEN-1:0] ex_result_a,
    output logic [`DI_XLEN-1:0] ex_result_b,
    output logic                br_a,
    output logic [63:0]         mul_lo_part,
    output logic [63:0]         mul_hi_part
);

    function automatic logic [`DI_XLEN-1:0] alu(
        input alu_op_e             op,
        input logic [`DI_XLEN-1:0] a,
        input logic [`DI_XLEN-1:0] b
    );
        logic [`DI_XLEN-1:0] res;
        unique case (op)
            OP_ADD:  res = a + b;
            OP_SUB:  res = a - b;
            OP_AND:  res = a & b;
            OP_OR:   res = a | b;
            OP_XOR:  res = a ^ b;
            OP_SLT:  res = {{(`DI_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            default: res = '0;  // NOP, MUL, BEQ, SYSCALL
        endcase
        return res;
    endfunction

    assign ex_valid    = head_valid;
    assign ex_pc_a     = head_pc_a;
    assign ex_pc_b     = head_pc_b;
    assign ex_op_a     = head_op_a;
    assign ex_op_b     = head_op_b;
    assign ex_rd_a     = head_rd_a;
    assign ex_rd_b     = head_rd_b;
    assign ex_we_a     = head_we_a && (head_op_a != OP_BEQ);  // Branch has no destination
    assign ex_we_b     = head_we_b;
    assign ex_result_a = alu(head_op_a, head_src1_a, head_src2_a);
    assign ex_result_b = alu(head_op_b, head_src1_b, head_src2_b);

    // Taken branch, squashes the younger slot
    assign br_a = head_valid && (head_op_a == OP_BEQ) && (head_src1_a == head_src2_a);

    // Multiply split on src2 halves, summed in MEM
    assign mul_lo_part = (head_op_b == OP_MUL) ?
                         64'(head_src1_b) * 64'(head_src2_b[15:0]) : '0;
    assign mul_hi_part = (head_op_b == OP_MUL) ?
                         64'(head_src1_b) * 64'(head_src2_b[`DI_XLEN-1:16]) : '0;

endmodule

//--- hw/issue_buffer.sv
`timescale 1ns/1ps
`include "dual_issue_params.svh"

module issue_buffer import dual_issue_pkg::*; (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                in_valid,
    input  logic [`DI_XLEN-1:0] in_pc_a,
    input  alu_op_e             in_op_a,
    input  logic [`DI_XLEN-1:0] in_src1_a,
    input  logic [`DI_XLEN-1:0] in_src2_a,
    input  logic [4:0]          in_rd_a,
    input  logic                in_we_a,
    input  logic [`DI_XLEN-1:0] in_pc_b,
    input  alu_op_e             in_op_b,
    input  logic [`DI_XLEN-1:0] in_src1_b,
    input  logic [`DI_XLEN-1:0] in_src2_b,
    input  logic [4:0]          in_rd_b,
    input  logic                in_we_b,
    input  logic                advance,
    input  logic                flush,
    output logic                in_credit,
    output logic                head_valid,
    output logic [`DI_XLEN-1:0] head_pc_a,
    output alu_op_e             head_op_a,
    output logic [`DI_XLEN-1:0] head_src1_a,
    output logic [`DI_XLEN-1:0] head_src2_a,
    output logic [4:0]          head_rd_a,
    output logic                head_we_a,
    output logic [`DI_XLEN-1:0] head_pc_b,
    output alu_op_e             head_op_b,
    output logic [`DI_XLEN-1:0] head_src1_b,
    output logic [`DI_XLEN-1:0] head_src2_b,
    output logic [4:0]          head_rd_b,
    output logic                head_we_b
);

    localparam int PTR_W = $clog2(`DI_ISSUE_DEPTH);
    localparam logic [PTR_W-1:0] LAST = PTR_W'(`DI_ISSUE_DEPTH - 1);

    logic [`DI_XLEN-1:0] pc_a_q [`DI_ISSUE_DEPTH];
    logic [`DI_XLEN-1:0] pc_b_q [`DI_ISSUE_DEPTH];
    alu_op_e             op_a_q [`DI_ISSUE_DEPTH];
    alu_op_e             op_b_q [`DI_ISSUE_DEPTH];
    logic [`DI_XLEN-1:0] src1_a_q [`DI_ISSUE_DEPTH];
    logic [`DI_XLEN-1:0] src1_b_q [`DI_ISSUE_DEPTH];
    logic [`DI_XLEN-1:0] src2_a_q [`DI_ISSUE_DEPTH];
    logic [`DI_XLEN-1:0] src2_b_q [`DI_ISSUE_DEPTH];
    logic [4:0]          rd_a_q [`DI_ISSUE_DEPTH];
    logic [4:0]          rd_b_q [`DI_ISSUE_DEPTH];
    logic                we_a_q [`DI_ISSUE_DEPTH];
    logic                we_b_q [`DI_ISSUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr, rd_ptr;
    logic [PTR_W:0]   count;
    logic             pop;

    assign head_valid = count != '0;
    assign pop        = head_valid && (advance || flush);  // Flush discards the head
    assign in_credit  = pop;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (in_valid)
                wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
            count <= count + in_valid - pop;  // Upstream credits rule out overflow
        end
    end

    // Pair storage
    always_ff @(posedge clk) begin
        if (in_valid) begin
            pc_a_q[wr_ptr]   <= in_pc_a;
            op_a_q[wr_ptr]   <= in_op_a;
            src1_a_q[wr_ptr] <= in_src1_a;
            src2_a_q[wr_ptr] <= in_src2_a;
            rd_a_q[wr_ptr]   <= in_rd_a;
            we_a_q[wr_ptr]   <= in_we_a;
            pc_b_q[wr_ptr]   <= in_pc_b;
            op_b_q[wr_ptr]   <= in_op_b;
            src1_b_q[wr_ptr] <= in_src1_b;
            src2_b_q[wr_ptr] <= in_src2_b;
            rd_b_q[wr_ptr]   <= in_rd_b;
            we_b_q[wr_ptr]   <= in_we_b;
        end
    end

    assign head_pc_a   = pc_a_q[rd_ptr];
    assign head_op_a   = op_a_q[rd_ptr];
    assign head_src1_a = src1_a_q[rd_ptr];
    assign head_src2_a = src2_a_q[rd_ptr];
    assign head_rd_a   = rd_a_q[rd_ptr];
    assign head_we_a   = we_a_q[rd_ptr];
    assign head_pc_b   = pc_b_q[rd_ptr];
    assign head_op_b   = op_b_q[rd_ptr];
    assign head_src1_b = src1_b_q[rd_ptr];
    assign head_src2_b = src2_b_q[rd_ptr];
    assign head_rd_b   = rd_b_q[rd_ptr];
    assign head_we_b   = we_b_q[rd_ptr];

endmodule

//--- hw/mem_stage.sv
`timescale 1ns/1ps
`include "dual_issue_params.svh"

module mem_stage import dual_issue_pkg::*; (
    input  alu_op_e             mem_op_a,
    input  alu_op_e             mem_op_b,
    input  logic [`DI_XLEN-1:0] mem_result_a,
    input  logic [`DI_XLEN-1:0] mem_result_b,
    input  logic [63:0]         mem_mul_lo,
    input  logic [63:0]         mem_mul_hi,
    output logic [`DI_XLEN-1:0] mem_wdata_a,
    output logic [`DI_XLEN-1:0] mem_wdata_b,
    output ecode_e              mem_ecode_a,
    output ecode_e              mem_ecode_b
);

    logic [63:0] mul_sum;

    // High partial carries weight 2^16
    assign mul_sum = mem_mul_lo + (mem_mul_hi << 16);

    assign mem_wdata_a = mem_result_a;
    assign mem_wdata_b = (mem_op_b == OP_MUL) ? mul_sum[`DI_XLEN-1:0] : mem_result_b;

    always_comb begin
        case (mem_op_a)
            OP_SYSCALL: mem_ecode_a = ECODE_SYS;
            OP_MUL:     mem_ecode_a = ECODE_ILLEGAL;  // No multiplier in slot A
            default:    mem_ecode_a = ECODE_NONE;
        endcase
    end

    always_comb begin
        case (mem_op_b)
            OP_SYSCALL: mem_ecode_b = ECODE_SYS;
            OP_BEQ:     mem_ecode_b = ECODE_ILLEGAL;  // Branches resolve in A only
            default:    mem_ecode_b = ECODE_NONE;
        endcase
    end

endmodule

//--- hw/retire_port.sv
`timescale 1ns/1ps
`include "dual_issue_params.svh"

module retire_port (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                retire_credit,
    input  logic                wb_valid,
    input  logic [`DI_XLEN-1:0] wb_pc_a,
    input  logic [`DI_XLEN-1:0] wb_pc_b,
    input  logic                wb_we_a,
    input  logic                wb_we_b,
    input  logic [4:0]          wb_rd_a,
    input  logic [4:0]          wb_rd_b,
    input  logic [`DI_XLEN-1:0] wb_wdata_a,
    input  logic [`DI_XLEN-1:0] wb_wdata_b,
    output logic                stall,
    output logic                retire_valid,
    output logic [`DI_XLEN-1:0] retire_pc_a,
    output logic [`DI_XLEN-1:0] retire_pc_b,
    output logic                retire_we_a,
    output logic                retire_we_b,
    output logic [4:0]          retire_rd_a,
    output logic [4:0]          retire_rd_b,
    output logic [`DI_XLEN-1:0] retire_wdata_a,
    output logic [`DI_XLEN-1:0] retire_wdata_b
);

    localparam int CNT_W = $clog2(`DI_RETIRE_CREDITS + 1);

    logic [CNT_W-1:0] credits;
    logic             has_credit;

    assign has_credit   = credits != '0;
    assign retire_valid = wb_valid && has_credit;
    assign stall        = wb_valid && !has_credit;  // Record waits in WB

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credits <= CNT_W'(`DI_RETIRE_CREDITS);
        end else begin
            case ({retire_credit, retire_valid})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;  // Both or neither
            endcase
        end
    end

    assign retire_pc_a    = wb_pc_a;
    assign retire_pc_b    = wb_pc_b;
    assign retire_we_a    = wb_we_a;
    assign retire_we_b    = wb_we_b;
    assign retire_rd_a    = wb_rd_a;
    assign retire_rd_b    = wb_rd_b;
    assign retire_wdata_a = wb_wdata_a;
    assign retire_wdata_b = wb_wdata_b;

endmodule

//--- hw/stage_regs.sv
`timescale 1ns/1ps
`include "dual_issue_params.svh"

module stage_regs import dual_issue_pkg::*; (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                stall,
    input  logic                flush,
    input  logic                ex_valid,
    input  logic [`DI_XLEN-1:0] ex_pc_a,
    input  logic [`DI_XLEN-1:0] ex_pc_b,
    input  alu_op_e             ex_op_a,
    input  alu_op_e             ex_op_b,
    input  logic [4:0]          ex_rd_a,
    input  logic [4:0]          ex_rd_b,
    input  logic                ex_we_a,
    input  logic                ex_we_b,
    input  logic [`DI_XLEN-1:0] ex_result_a,
    input  logic [`DI_XLEN-1:0] ex_result_b,
    input  logic                br_a,
    input  logic [63:0]         mul_lo_part,
    input  logic [63:0]         mul_hi_part,
    input  logic [`DI_XLEN-1:0] mem_wdata_a,
    input  logic [`DI_XLEN-1:0] mem_wdata_b,
    input  ecode_e              mem_ecode_a,
    input  ecode_e              mem_ecode_b,
    output logic                mem_valid,
    output logic [`DI_XLEN-1:0] mem_pc_a,
    output logic [`DI_XLEN-1:0] mem_pc_b,
    output alu_op_e             mem_op_a,
    output alu_op_e             mem_op_b,
    output logic [`DI_XLEN-1:0] mem_result_a,
    output logic [`DI_XLEN-1:0] mem_result_b,
    output logic [63:0]         mem_mul_lo,
    output logic [63:0]         mem_mul_hi,
    output logic                wb_valid,
    output logic [`DI_XLEN-1:0] wb_pc_a,
    output logic [`DI_XLEN-1:0] wb_pc_b,
    output logic                wb_we_a,
    output logic                wb_we_b,
    output logic [4:0]          wb_rd_a,
    output logic [4:0]          wb_rd_b,
    output logic [`DI_XLEN-1:0] wb_wdata_a,
    output logic [`DI_XLEN-1:0] wb_wdata_b
);

    logic [4:0] mem_rd_a, mem_rd_b;
    logic       mem_we_a, mem_we_b;
    logic       kill_a, kill_b;

    // An exception in the older slot also kills the younger one
    assign kill_a = mem_ecode_a != ECODE_NONE;
    assign kill_b = kill_a || (mem_ecode_b != ECODE_NONE);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_valid <= 1'b0;
            mem_op_a  <= OP_NOP;
            mem_op_b  <= OP_NOP;
            {mem_pc_a, mem_pc_b, mem_rd_a, mem_rd_b, mem_we_a, mem_we_b} <= '0;
            {mem_result_a, mem_result_b, mem_mul_lo, mem_mul_hi} <= '0;
            wb_valid  <= 1'b0;
            {wb_pc_a, wb_pc_b, wb_rd_a, wb_rd_b, wb_we_a, wb_we_b} <= '0;
            {wb_wdata_a, wb_wdata_b} <= '0;
        end else if (flush) begin  // Wins over stall
            mem_valid <= 1'b0;
            mem_op_a  <= OP_NOP;
            mem_op_b  <= OP_NOP;
            {mem_pc_a, mem_pc_b, mem_rd_a, mem_rd_b, mem_we_a, mem_we_b} <= '0;
            {mem_result_a, mem_result_b, mem_mul_lo, mem_mul_hi} <= '0;
            wb_valid  <= 1'b0;
            {wb_pc_a, wb_pc_b, wb_rd_a, wb_rd_b, wb_we_a, wb_we_b} <= '0;
            {wb_wdata_a, wb_wdata_b} <= '0;
        end else if (!stall) begin
            // EX to MEM
            mem_valid    <= ex_valid;
            mem_pc_a     <= ex_pc_a;
            mem_op_a     <= ex_op_a;
            mem_rd_a     <= ex_rd_a;
            mem_we_a     <= ex_we_a;
            mem_result_a <= ex_result_a;
            if (br_a) begin
                mem_pc_b     <= '0;
                mem_op_b     <= OP_NOP;
                mem_rd_b     <= '0;
                mem_we_b     <= 1'b0;
                mem_result_b <= '0;
                mem_mul_lo   <= '0;
                mem_mul_hi   <= '0;
            end else begin
                mem_pc_b     <= ex_pc_b;
                mem_op_b     <= ex_op_b;
                mem_rd_b     <= ex_rd_b;
                mem_we_b     <= ex_we_b;
                mem_result_b <= ex_result_b;
                mem_mul_lo   <= mul_lo_part;
                mem_mul_hi   <= mul_hi_part;
            end

            // MEM to WB
            wb_valid   <= mem_valid;
            wb_pc_a    <= mem_pc_a;
            wb_pc_b    <= mem_pc_b;
            wb_rd_a    <= mem_rd_a;
            wb_rd_b    <= mem_rd_b;
            wb_we_a    <= mem_we_a && !kill_a;
            wb_we_b    <= mem_we_b && !kill_b;
            wb_wdata_a <= mem_wdata_a;
            wb_wdata_b <= mem_wdata_b;
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_dual_issue \
    -Mdir obj_dir -f filelist.f

./obj_dir/Vtb_dual_issue > sim.log 2>&1
cat sim.log

if grep -q "TEST FAIL" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
echo "Simulation finished without failure"
exit 0

//--- sim/tb_checker.sv
`timescale 1ns/1ps
`include "dual_issue_params.svh"

module tb_checker (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                exp_push,
    input  logic [31:0]         exp_test,
    input  logic [`DI_XLEN-1:0] exp_pc_a,
    input  logic [`DI_XLEN-1:0] exp_pc_b,
    input  logic                exp_we_a,
    input  logic                exp_we_b,
    input  logic [4:0]          exp_rd_a,
    input  logic [4:0]          exp_rd_b,
    input  logic [`DI_XLEN-1:0] exp_wdata_a,
    input  logic [`DI_XLEN-1:0] exp_wdata_b,
    input  logic                retire_valid,
    input  logic                retire_credit,
    input  logic [`DI_XLEN-1:0] retire_pc_a,
    input  logic [`DI_XLEN-1:0] retire_pc_b,
    input  logic                retire_we_a,
    input  logic                retire_we_b,
    input  logic [4:0]          retire_rd_a,
    input  logic [4:0]          retire_rd_b,
    input  logic [`DI_XLEN-1:0] retire_wdata_a,
    input  logic [`DI_XLEN-1:0] retire_wdata_b,
    output int                  n_pending,
    output int                  n_errors,
    output int                  n_pass,
    output int                  n_fail
);

    // One queue entry per expected record
    int                  q_test[$];
    logic [`DI_XLEN-1:0] q_pc_a[$], q_pc_b[$], q_wdata_a[$], q_wdata_b[$];
    logic                q_we_a[$], q_we_b[$];
    logic [4:0]          q_rd_a[$], q_rd_b[$];

    int pending [16];   // Records still owed per test
    bit test_bad [16];
    int credit_model;   // Retire credits granted and not yet used

    initial begin
        n_pending    = 0;
        n_errors     = 0;
        n_pass       = 0;
        n_fail       = 0;
        credit_model = `DI_RETIRE_CREDITS;
        for (int i = 0; i < 16; i++) begin
            pending[i]  = 0;
            test_bad[i] = 1'b0;
        end
    end

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp, input int t);
        if (got !== exp) begin
            $display("** Error at %0d ns: test %0d, %s is %h, expected %h",
                     $time, t, name, got, exp);
            n_errors++;
            test_bad[t] = 1'b1;
        end
    endtask

    always @(posedge clk) begin
        int t;
        if (arst_n) begin
            if (exp_push) begin
                q_test.push_back(int'(exp_test));
                q_pc_a.push_back(exp_pc_a);
                q_pc_b.push_back(exp_pc_b);
                q_we_a.push_back(exp_we_a);
                q_we_b.push_back(exp_we_b);
                q_rd_a.push_back(exp_rd_a);
                q_rd_b.push_back(exp_rd_b);
                q_wdata_a.push_back(exp_wdata_a);
                q_wdata_b.push_back(exp_wdata_b);
                pending[exp_test[3:0]]++;
                n_pending++;
            end
            if (retire_valid && credit_model == 0) begin
                $display("Retirement at %0d ns while the consumer had granted no credit",
                         $time);
                n_errors++;
            end
            credit_model = credit_model + int'(retire_credit) - int'(retire_valid);
            if (retire_valid) begin
                if (q_test.size() == 0) begin
                    $display("Unexpected retirement at %0d ns with no record left to match",
                             $time);
                    n_errors++;
                end else begin
                    t = q_test.pop_front();
                    check_field("pc_a", retire_pc_a, q_pc_a.pop_front(), t);
                    check_field("pc_b", retire_pc_b, q_pc_b.pop_front(), t);
                    check_field("we_a", 32'(retire_we_a), 32'(q_we_a.pop_front()), t);
                    check_field("we_b", 32'(retire_we_b), 32'(q_we_b.pop_front()), t);
                    check_field("rd_a", 32'(retire_rd_a), 32'(q_rd_a.pop_front()), t);
                    check_field("rd_b", 32'(retire_rd_b), 32'(q_rd_b.pop_front()), t);
                    check_field("wdata_a", retire_wdata_a, q_wdata_a.pop_front(), t);
                    check_field("wdata_b", retire_wdata_b, q_wdata_b.pop_front(), t);
                    n_pending--;
                    pending[t]--;
                    if (pending[t] == 0) begin  // Last record of this test
                        if (test_bad[t]) begin
                            n_fail++;
                            $display("Test %0d failed", t);
                        end else begin
                            n_pass++;
                            $display("Test %0d passed", t);
                        end
                    end
                end
            end
        end
    end

endmodule

//--- sim/tb_dual_issue.sv
`timescale 1ns/1ps
`include "dual_issue_params.svh"

module tb_dual_issue import dual_issue_pkg::*; ();

    logic                clk, arst_n, flush;
    logic                in_valid, in_credit, in_we_a, in_we_b;
    logic [`DI_XLEN-1:0] in_pc_a, in_src1_a, in_src2_a, in_pc_b, in_src1_b, in_src2_b;
    alu_op_e             in_op_a, in_op_b;
    logic [4:0]          in_rd_a, in_rd_b;
    logic                retire_credit = 1'b0;
    logic                retire_valid, retire_we_a, retire_we_b;
    logic [`DI_XLEN-1:0] retire_pc_a, retire_pc_b, retire_wdata_a, retire_wdata_b;
    logic [4:0]          retire_rd_a, retire_rd_b;

    // Expected record towards the checker
    logic                exp_push, exp_we_a, exp_we_b;
    logic [31:0]         exp_test;
    logic [`DI_XLEN-1:0] exp_pc_a, exp_pc_b, exp_wdata_a, exp_wdata_b;
    logic [4:0]          exp_rd_a, exp_rd_b;
    int                  n_pending, n_errors, n_pass, n_fail;

    logic [31:0] fld [13];        // Fields of the current data line
    int  in_credits = `DI_ISSUE_DEPTH;
    int  owed = 0;                // Retired records not yet credited back
    logic hold;                   // Retire credits held at zero
    int  watchdog_cycles = 0;

    dual_issue_top i_dut (.*);

    tb_checker i_checker (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Upstream credit count as the DUT sees it
    always @(posedge clk) begin
        if (!arst_n)
            in_credits <= `DI_ISSUE_DEPTH;
        else
            in_credits <= in_credits + int'(in_credit) - int'(in_valid);
    end

    // Retire consumer returns credits at random gaps
    initial begin
        int avail;
        void'($urandom(32'h8905_af6d));
        forever begin
            @(posedge clk);
            avail = owed + int'(retire_valid);
            if (!arst_n) begin
                owed          <= 0;
                retire_credit <= 1'b0;
            end else if (!hold && avail > 0 && ($urandom % 3 == 0)) begin
                owed          <= avail - 1;
                retire_credit <= 1'b1;
            end else begin
                owed          <= avail;
                retire_credit <= 1'b0;
            end
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        in_valid <= 1'b0;
        exp_push <= 1'b0;
        flush    <= 1'b0;
    endtask

    task automatic issue_pair();
        bit sent;
        sent = 0;
        while (!sent) begin
            next_cycle();
            if (in_credits - int'(in_valid) + int'(in_credit) > 0) begin
                in_valid  <= 1'b1;
                in_pc_a   <= fld[1];
                in_op_a   <= alu_op_e'(fld[2][3:0]);
                in_src1_a <= fld[3];
                in_src2_a <= fld[4];
                in_rd_a   <= fld[5][4:0];
                in_we_a   <= fld[6][0];
                in_pc_b   <= fld[7];
                in_op_b   <= alu_op_e'(fld[8][3:0]);
                in_src1_b <= fld[9];
                in_src2_b <= fld[10];
                in_rd_b   <= fld[11][4:0];
                in_we_b   <= fld[12][0];
                sent = 1;
            end
        end
    endtask

    task automatic push_expected();
        next_cycle();
        exp_push    <= 1'b1;
        exp_test    <= fld[0];
        exp_pc_a    <= fld[1];
        exp_pc_b    <= fld[2];
        exp_we_a    <= fld[3][0];
        exp_we_b    <= fld[4][0];
        exp_rd_a    <= fld[5][4:0];
        exp_rd_b    <= fld[6][4:0];
        exp_wdata_a <= fld[7];
        exp_wdata_b <= fld[8];
    endtask

    // Wait for an empty pipeline and all credits back
    task automatic drain(input int max_cycles);
        int n;
        n = 0;
        do begin
            next_cycle();
            n++;
            @(negedge clk);  // Counters have settled by now
        end while ((n_pending != 0 || owed != 0 || in_credits != `DI_ISSUE_DEPTH)
                   && n < max_cycles);
    endtask

    initial begin
        int fd, r, p_lines;
        logic [63:0] kind;
        logic [8*256-1:0] line;
        bit eof, file_error, credit_error;
        {in_valid, flush, exp_push, hold} = '0;
        {in_pc_a, in_src1_a, in_src2_a, in_rd_a, in_we_a} = '0;
        {in_pc_b, in_src1_b, in_src2_b, in_rd_b, in_we_b} = '0;
        in_op_a = OP_NOP;
        in_op_b = OP_NOP;
        arst_n  = 1'b0;
        p_lines = 0;

        fd = $fopen("sim/testdata_pairs.txt", "r");
        file_error = (fd == 0);
        if (file_error) begin
            $display("Test data file sim/testdata_pairs.txt could not be opened");
        end else begin
            while ($fscanf(fd, "%s", kind) == 1) begin
                if (kind == "P")
                    p_lines++;
                r = $fgets(line, fd);
            end
            $fclose(fd);
        end
        watchdog_cycles = p_lines * 40 + 200;

        repeat (3) @(posedge clk);
        arst_n <= 1'b1;

        fd  = file_error ? 0 : $fopen("sim/testdata_pairs.txt", "r");
        eof = (fd == 0);
        while (!eof) begin
            r = $fscanf(fd, "%s", kind);
            if (r != 1) begin
                eof = 1;
            end else if (kind == "P") begin
                r = $fscanf(fd, "%d %h %h %h %h %h %h %h %h %h %h %h %h",
                            fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6],
                            fld[7], fld[8], fld[9], fld[10], fld[11], fld[12]);
                issue_pair();
            end else if (kind == "E") begin
                r = $fscanf(fd, "%d %h %h %h %h %h %h %h %h", fld[0], fld[1], fld[2],
                            fld[3], fld[4], fld[5], fld[6], fld[7], fld[8]);
                push_expected();
            end else if (kind == "S") begin
                drain(400);
                hold <= 1'b1;
            end else if (kind == "R") begin
                repeat (10) next_cycle();
                hold <= 1'b0;
            end else if (kind == "F") begin
                repeat (8) next_cycle();  // Let the pipeline fill
                flush <= 1'b1;
            end else begin
                r = $fgets(line, fd);     // Comment line
            end
        end
        if (fd != 0)
            $fclose(fd);

        drain(400);
        repeat (20) next_cycle();         // Catch late extra retirements
        @(negedge clk);
        if (n_pending != 0)
            $display("%0d expected retire records never arrived", n_pending);
        credit_error = (in_credits != `DI_ISSUE_DEPTH);
        if (credit_error)
            $display("Upstream credits not all returned, %0d of %0d held",
                     in_credits, `DI_ISSUE_DEPTH);
        $display("Tests passed %0d, tests failed %0d, errors %0d",
                 n_pass, n_fail, n_errors);
        if (file_error || credit_error || n_pending != 0 || n_errors != 0 || n_fail != 0)
            $display("TEST FAIL");
        else
            $display("TEST PASS");
        $finish;
    end

    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run did not finish",
                 watchdog_cycles);
        $display("TEST FAIL");
        $finish;
    end

endmodule

//--- sim/testdata_pairs.txt
# P test pc_a op_a src1_a src2_a rd_a we_a pc_b op_b src1_b src2_b rd_b we_b
# E test pc_a pc_b we_a we_b rd_a rd_b wdata_a wdata_b, S hold credits, R release, F flush
E 1 100 104 1 1 1 2 c 7
E 1 108 10c 1 1 3 4 f000 3f
E 1 110 114 1 1 5 6 55555555 1
E 1 118 11c 1 1 7 8 0 1
P 1 100 1 5 7 1 1 104 2 a 3 2 1
P 1 108 3 f0f0 ff00 3 1 10c 4 f 30 4 1
P 1 110 5 aaaa5555 ffff0000 5 1 114 6 ffffffff 1 6 1
P 1 118 6 5 ffffffff 7 1 11c 1 ffffffff 2 8 1
E 2 200 0 0 0 0 0 0 0
E 2 208 20c 0 1 0 9 0 2
P 2 200 8 9 9 0 1 204 1 1 1 9 1
P 2 208 8 9 8 0 0 20c 1 1 1 9 1
E 3 300 304 1 1 1 a 3 69d1468a
E 3 308 30c 0 1 0 b 0 1
P 3 300 1 1 2 1 1 304 7 12345 30002 a 1
P 3 308 5 0 0 0 0 30c 7 ffffffff ffffffff b 1
E 4 400 404 0 0 1 2 0 5
E 4 408 40c 1 0 3 4 5 0
E 4 410 414 0 0 5 6 0 3
E 4 418 41c 1 0 7 8 5 0
P 4 400 9 0 0 1 1 404 1 2 3 2 1
P 4 408 1 2 3 3 1 40c 9 0 0 4 1
P 4 410 7 3 3 5 1 414 4 1 2 6 1
P 4 418 2 9 4 7 1 41c 8 1 1 8 1
S
E 5 500 504 1 1 1 2 2 4
E 5 508 50c 1 1 3 4 6 2
E 5 510 514 1 1 5 6 11 f
E 5 518 51c 1 1 7 8 2 1
E 5 520 524 1 1 9 a 123 e
P 5 500 1 1 1 1 1 504 1 2 2 2 1
P 5 508 1 3 3 3 1 50c 2 3 1 4 1
P 5 510 4 10 1 5 1 514 3 ff f 6 1
P 5 518 5 1 3 7 1 51c 6 1 2 8 1
P 5 520 1 100 23 9 1 524 1 7 7 a 1
R
S
E 6 600 604 1 1 1 2 1 2
E 6 608 60c 1 1 3 4 3 4
E 6 628 62c 1 1 9 a 9 a
P 6 600 1 1 0 1 1 604 1 2 0 2 1
P 6 608 1 3 0 3 1 60c 1 4 0 4 1
P 6 610 1 5 0 5 1 614 1 6 0 6 1
P 6 618 1 7 0 7 1 61c 1 8 0 8 1
P 6 620 1 b 0 b 1 624 1 c 0 c 1
P 6 628 1 9 0 9 1 62c 1 a 0 a 1
F
R
